//--- design/lsu_defines.svh
// ======================================
// LSU subsystem build parameters
// Data width and data RAM geometry
// ======================================

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Data and address width in bits
`define LSU_XLEN 32

// Data RAM depth in 32-bit words
`define LSU_RAM_WORDS 256

// Wait states the RAM adds to every ACCESS phase
`define LSU_RAM_WAIT 1

`endif

//--- design/lsu_pkg.sv
// ======================================
// LSU subsystem types
// Instruction, opcode, pipeline and APB records
// ======================================

`include "lsu_defines.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]   word_t;
    typedef logic [`LSU_XLEN/8-1:0] wstrobe_t;

    // RV32 major opcodes handled by the pipeline
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011
    } opcode_e;

    // Access width, 000 doubles as ADDI under OP-IMM
    typedef enum logic [2:0] {
        FUNCT3_LB_SB = 3'b000,
        FUNCT3_LH_SH = 3'b001,
        FUNCT3_LW_SW = 3'b010,
        FUNCT3_LBU   = 3'b100,
        FUNCT3_LHU   = 3'b101
    } funct3_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instruction_t;

    typedef enum logic [1:0] {
        MK_LOAD,
        MK_STORE,
        MK_ALU
    } mem_kind_e;

    // Decode to memory stage
    typedef struct packed {
        logic       valid;
        mem_kind_e  kind;
        logic [2:0] funct3;
        word_t      addr;        // Effective address or ADDI result
        word_t      store_data;
        logic [4:0] rd;
        logic       misaligned;
    } mem_op_t;

    typedef struct packed {
        logic     psel;
        logic     penable;
        logic     pwrite;
        word_t    paddr;
        word_t    pwdata;
        wstrobe_t pstrb;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
    } apb_rsp_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] rd;
        word_t      data;
        logic       fault;
    } wb_t;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_e;

endpackage

//--- design/register_file.sv
// ======================================
// Integer register file, 2 read / 1 write
// ======================================

`timescale 1ns/1ps

module register_file
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic [4:0] rs1_addr,
    input  logic [4:0] rs2_addr,
    output word_t      rs1_data,
    output word_t      rs2_data,
    input  wb_t        wb
);

    word_t regs [32];
    logic  wr_en;

    // Faulting retirements leave the registers alone
    assign wr_en = wb.valid && !wb.fault && (wb.rd != 5'd0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // x0 hardwired to zero
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

//--- design/lsu_decode_stage.sv
// ======================================
// Decode stage: operand read, address generation,
// alignment check and register hazard stall
// ======================================

`timescale 1ns/1ps

module lsu_decode_stage
    import lsu_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         instr_valid,
    input  instruction_t instr,
    output logic         instr_ready,
    output logic [4:0]   rs1_addr,
    output logic [4:0]   rs2_addr,
    input  word_t        rs1_data,
    input  word_t        rs2_data,
    output mem_op_t      op,
    input  logic         op_ready,
    input  wb_t          wb
);

    logic        is_load;
    logic        is_store;
    logic        is_addi;
    logic        known;
    logic        started;     // Opens the input port one cycle after reset
    logic        advance;
    logic        hazard;
    logic        accept;
    logic        misaligned;
    logic        writes_rd;
    logic [31:0] pending;     // One bit per destination still in flight
    logic [31:0] pend_set;
    logic [31:0] pend_clr;
    word_t       imm_i;
    word_t       imm_s;
    word_t       sum;

    // ======================================
    // Instruction decode
    // ======================================
    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_addi  = 1'b0;
        case (instr.opcode)
            OPC_LOAD:   is_load  = instr.funct3 inside {FUNCT3_LB_SB, FUNCT3_LH_SH,
                                                        FUNCT3_LW_SW, FUNCT3_LBU, FUNCT3_LHU};
            OPC_STORE:  is_store = instr.funct3 inside {FUNCT3_LB_SB, FUNCT3_LH_SH,
                                                        FUNCT3_LW_SW};
            OPC_OP_IMM: is_addi  = (instr.funct3 == FUNCT3_LB_SB);
            default:    ; // Anything else is dropped here
        endcase
    end

    assign known = is_load || is_store || is_addi;

    assign imm_i = {{20{instr.funct7[6]}}, instr.funct7, instr.rs2};
    assign imm_s = {{20{instr.funct7[6]}}, instr.funct7, instr.rd};
    assign sum   = rs1_data + (is_store ? imm_s : imm_i);

    // Halfword needs bit 0 clear, word needs both low bits clear
    always_comb begin
        misaligned = 1'b0;
        if (is_load || is_store) begin
            case (instr.funct3[1:0])
                2'b01:   misaligned = sum[0];
                2'b10:   misaligned = |sum[1:0];
                default: misaligned = 1'b0;
            endcase
        end
    end

    assign rs1_addr = instr.rs1;
    assign rs2_addr = instr.rs2;

    // ======================================
    // Hazard scoreboard
    // ======================================
    assign writes_rd = (is_load || is_addi) && !misaligned && (instr.rd != 5'd0);

    // RAW on sources, plus WAW on rd so a set and a clear never collide
    assign hazard = pending[instr.rs1]
                 || (is_store && pending[instr.rs2])
                 || (writes_rd && pending[instr.rd]);

    assign advance     = !op.valid || op_ready;
    assign instr_ready = started && advance && !hazard;
    assign accept      = instr_valid && instr_ready;

    assign pend_set = (accept && writes_rd) ? (32'd1 << instr.rd) : '0;
    assign pend_clr = (wb.valid && !wb.fault) ? (32'd1 << wb.rd) : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            started <= 1'b0;
            pending <= '0;
        end else begin
            started <= 1'b1;
            pending <= (pending & ~pend_clr) | pend_set;
        end
    end

    // ======================================
    // Output register to the memory stage
    // ======================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op <= '0;
        end else if (advance) begin
            op.valid      <= accept && known;
            op.kind       <= is_load ? MK_LOAD : (is_store ? MK_STORE : MK_ALU);
            op.funct3     <= instr.funct3;
            op.addr       <= sum;
            op.store_data <= rs2_data;
            op.rd         <= instr.rd;
            op.misaligned <= misaligned;
        end
    end

endmodule

//--- design/load_store_unit.sv
// ======================================
// Load/store lane logic: byte strobes,
// store replication and load extension
// ======================================

`timescale 1ns/1ps

module load_store_unit
    import lsu_pkg::*;
(
    input  instruction_t instr,
    input  word_t        address,
    input  logic         store_enable,
    input  word_t        store_data,
    output word_t        load_data,
    input  word_t        rdata,
    output wstrobe_t     wstrobe,
    output word_t        wdata
);

    logic [2:0]  size;        // Access size in bytes
    logic [1:0]  offset;      // Byte position within the word
    logic [15:0] half_lane;
    logic [7:0]  byte_lane;

    assign offset = address[1:0];

    // Size and replicated write data
    always_comb begin
        case (instr.funct3)
            FUNCT3_LB_SB, FUNCT3_LBU: begin
                size  = 3'd1;
                wdata = {4{store_data[7:0]}};
            end
            FUNCT3_LH_SH, FUNCT3_LHU: begin
                size  = 3'd2;
                wdata = {2{store_data[15:0]}};
            end
            FUNCT3_LW_SW: begin
                size  = 3'd4;
                wdata = store_data;
            end
            default: begin
                size  = 3'd0;
                wdata = store_data;
            end
        endcase
    end

    // Strobe each lane covered by [offset, offset + size)
    always_comb begin
        for (int lane = 0; lane < 4; lane++) begin
            wstrobe[lane] = store_enable
                         && (lane >= int'(offset))
                         && (lane < int'(offset) + int'(size));
        end
    end

    assign half_lane = offset[1] ? rdata[31:16] : rdata[15:0];
    assign byte_lane = rdata[8*offset +: 8];

    always_comb begin
        case (instr.funct3)
            FUNCT3_LB_SB: load_data = {{24{byte_lane[7]}}, byte_lane};
            FUNCT3_LBU:   load_data = {24'd0, byte_lane};
            FUNCT3_LH_SH: load_data = {{16{half_lane[15]}}, half_lane};
            FUNCT3_LHU:   load_data = {16'd0, half_lane};
            default:      load_data = rdata;
        endcase
    end

endmodule

//--- design/lsu_memory_stage.sv
// ======================================
// Memory stage: APB master around the
// load/store unit, issues the writeback
// ======================================

`timescale 1ns/1ps

module lsu_memory_stage
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  mem_op_t  op,
    output logic     op_ready,
    output apb_req_t apb_req,
    input  apb_rsp_t apb_rsp,
    output wb_t      wb
);

    apb_state_e   state;
    mem_op_t      cur_op;     // Op owning the bus
    instruction_t lsu_instr;
    word_t        load_data;
    word_t        wdata;
    wstrobe_t     wstrobe;
    logic         is_store;
    logic         take;
    logic         needs_bus;
    logic         done;

    assign op_ready  = (state == APB_IDLE);
    assign take      = op_ready && op.valid;
    assign needs_bus = (op.kind != MK_ALU) && !op.misaligned;
    assign is_store  = (cur_op.kind == MK_STORE);
    assign done      = (state == APB_ACCESS) && apb_rsp.pready;

    // Only funct3 and the direction matter to the lane logic
    always_comb begin
        lsu_instr        = '0;
        lsu_instr.opcode = is_store ? OPC_STORE : OPC_LOAD;
        lsu_instr.funct3 = cur_op.funct3;
    end

    load_store_unit u_lsu (
        .instr        (lsu_instr),
        .address      (cur_op.addr),
        .store_enable (is_store),
        .store_data   (cur_op.store_data),
        .load_data    (load_data),
        .rdata        (apb_rsp.prdata),
        .wstrobe      (wstrobe),
        .wdata        (wdata)
    );

    // ======================================
    // APB request
    // ======================================
    always_comb begin
        apb_req.psel    = (state != APB_IDLE);
        apb_req.penable = (state == APB_ACCESS);
        apb_req.pwrite  = is_store;
        apb_req.paddr   = cur_op.addr;
        apb_req.pwdata  = wdata;
        apb_req.pstrb   = wstrobe;   // All zero for loads
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= APB_IDLE;
        end else begin
            case (state)
                APB_IDLE:   if (take && needs_bus) state <= APB_SETUP;
                APB_SETUP:  state <= APB_ACCESS;
                APB_ACCESS: if (apb_rsp.pready) state <= APB_IDLE;
                default:    state <= APB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cur_op <= op;
        end
    end

    // ======================================
    // Writeback record
    // ======================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb <= '0;
        end else begin
            wb <= '0;
            if (take && !needs_bus) begin   // ALU result or alignment fault
                wb.valid <= 1'b1;
                wb.rd    <= (op.kind == MK_STORE) ? 5'd0 : op.rd;
                wb.data  <= op.misaligned ? '0 : op.addr;
                wb.fault <= op.misaligned;
            end else if (done) begin
                wb.valid <= 1'b1;
                wb.rd    <= is_store ? 5'd0 : cur_op.rd;
                wb.data  <= is_store ? '0 : load_data;
            end
        end
    end

endmodule

//--- design/data_ram_apb.sv
// ======================================
// APB data RAM with byte strobes and wait states
// ======================================

`timescale 1ns/1ps

`include "lsu_defines.svh"

module data_ram_apb
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    localparam int ADDR_W = $clog2(`LSU_RAM_WORDS);
    localparam int WAIT_W = $clog2(`LSU_RAM_WAIT + 2);

    word_t             mem [`LSU_RAM_WORDS];
    logic [ADDR_W-1:0] word_addr;
    logic [WAIT_W-1:0] wait_cnt;
    logic              access;

    assign access    = apb_req.psel && apb_req.penable;
    assign word_addr = apb_req.paddr[ADDR_W+1:2];   // Byte address to word index

    assign apb_rsp.pready = access && (wait_cnt == WAIT_W'(`LSU_RAM_WAIT));
    assign apb_rsp.prdata = mem[word_addr];

    // Counts ACCESS cycles, restarts after each transfer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else if (!access || apb_rsp.pready) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LSU_RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (apb_rsp.pready && apb_req.pwrite) begin
            for (int b = 0; b < `LSU_XLEN/8; b++) begin
                if (apb_req.pstrb[b]) begin
                    mem[word_addr][8*b +: 8] <= apb_req.pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- design/lsu_subsystem_top.sv
// ======================================
// RV32 load/store pipeline top level
// ======================================

`timescale 1ns/1ps

module lsu_subsystem_top
    import lsu_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         instr_valid,
    input  instruction_t instr,
    output logic         instr_ready,
    output wb_t          wb
);

    logic [4:0] rs1_addr;
    logic [4:0] rs2_addr;
    word_t      rs1_data;
    word_t      rs2_data;
    mem_op_t    op;
    logic       op_ready;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;

    register_file u_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    lsu_decode_stage u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .op          (op),
        .op_ready    (op_ready),
        .wb          (wb)
    );

    lsu_memory_stage u_mem (
        .clk      (clk),
        .arst_n   (arst_n),
        .op       (op),
        .op_ready (op_ready),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .wb       (wb)
    );

    data_ram_apb u_ram (
        .clk     (clk),
        .arst_n  (arst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

endmodule

//--- testbench/lsu_properties.sv
// ======================================
// APB master checks on the memory stage
// ======================================

`timescale 1ns/1ps

module lsu_properties
    import lsu_pkg::*;
(
    input logic       clk,
    input logic       arst_n,
    input apb_state_e state,
    input mem_op_t    op,
    input logic       op_ready,
    input apb_req_t   apb_req,
    input apb_rsp_t   apb_rsp
);

    int failures = 0;   // Failed checks so far

    // SETUP lasts one cycle and ACCESS keeps its request
    setup_to_access: assert property (@(posedge clk) disable iff (!arst_n)
        state == APB_SETUP |=> state == APB_ACCESS
                               && $stable(apb_req.paddr) && $stable(apb_req.pwrite)
                               && $stable(apb_req.pwdata) && $stable(apb_req.pstrb))
        else begin
            $error("APB SETUP not followed by a matching ACCESS");
            failures++;
        end

    // Wait states keep the whole request frozen
    req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        apb_req.psel && apb_req.penable && !apb_rsp.pready |=> $stable(apb_req))
        else begin
            $error("APB request changed during wait state");
            failures++;
        end

    read_no_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        apb_req.psel && !apb_req.pwrite |-> apb_req.pstrb == '0)
        else begin
            $error("APB read with nonzero pstrb");
            failures++;
        end

    // Decode keeps a refused op until the bus frees up
    stalled_op_held: assert property (@(posedge clk) disable iff (!arst_n)
        op.valid && !op_ready |=> op.valid && $stable(op))
        else begin
            $error("Op changed or vanished while the memory stage was busy");
            failures++;
        end

endmodule

bind lsu_memory_stage lsu_properties u_props (
    .clk      (clk),
    .arst_n   (arst_n),
    .state    (state),
    .op       (op),
    .op_ready (op_ready),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp)
);

//--- testbench/lsu_tb.sv
// ======================================
// LSU subsystem testbench
// Random load/store traffic against a model
// ======================================

`timescale 1ns/1ps

`include "lsu_defines.svh"

module lsu_tb
    import lsu_pkg::*;
();

    localparam int MEM_BYTES = `LSU_RAM_WORDS * 4;

    typedef struct packed {
        logic [4:0] rd;
        word_t      data;
        logic       fault;
        logic       check_rd;
        logic       check_data;
    } expect_t;

    logic         clk;
    logic         arst_n;
    logic         instr_valid;
    instruction_t instr;
    logic         instr_ready;
    wb_t          wb;

    integer     seed = 32'h5f5;
    int         errors;
    int         checks;
    int         sent;
    int         cycles;
    word_t      model_regs [32];
    logic [7:0] model_mem [MEM_BYTES];
    expect_t    exp_q [$];      // Writebacks still owed in program order

    lsu_subsystem_top dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .wb          (wb)
    );

    always #50 clk = ~clk;

    // ======================================
    // Reference model
    // ======================================
    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic int byte_index(input word_t addr);
        return int'(addr % MEM_BYTES);   // RAM aliases above its size
    endfunction

    function automatic void write_reg(input logic [4:0] rd, input word_t value);
        if (rd != 5'd0) begin
            model_regs[rd] = value;
        end
    endfunction

    task automatic predict(input instruction_t i);
        word_t       imm;
        word_t       addr;
        word_t       value;
        word_t       sdata;
        logic [7:0]  b;
        logic [15:0] h;
        int          n;
        logic        bad;
        expect_t     e;
        imm   = {{20{i.funct7[6]}}, i.funct7, (i.opcode == OPC_STORE) ? i.rd : i.rs2};
        addr  = model_regs[i.rs1] + imm;
        sdata = model_regs[i.rs2];
        bad   = 1'b0;
        if (i.funct3[1:0] == 2'b01) begin
            bad = addr[0];
        end else if (i.funct3[1:0] == 2'b10) begin
            bad = |addr[1:0];
        end
        b     = model_mem[byte_index(addr)];
        h     = {model_mem[byte_index(addr + 1)], b};
        value = {model_mem[byte_index(addr + 3)], model_mem[byte_index(addr + 2)], h};
        n     = (i.funct3[1:0] == 2'b00) ? 1 : ((i.funct3[1:0] == 2'b01) ? 2 : 4);
        e     = '0;
        if (i.opcode == OPC_OP_IMM && i.funct3 == 3'b000) begin
            e.rd         = i.rd;
            e.data       = addr;         // ADDI sum
            e.check_rd   = 1'b1;
            e.check_data = 1'b1;
            write_reg(i.rd, addr);
            exp_q.push_back(e);
        end else if (i.opcode == OPC_LOAD
                     && i.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
            if (bad) begin
                e.fault = 1'b1;
            end else begin
                case (i.funct3)
                    3'b000:  value = {{24{b[7]}}, b};
                    3'b100:  value = {24'd0, b};
                    3'b001:  value = {{16{h[15]}}, h};
                    3'b101:  value = {16'd0, h};
                    default: ;               // Whole word already assembled
                endcase
                e.rd         = i.rd;
                e.data       = value;
                e.check_rd   = 1'b1;
                e.check_data = 1'b1;
                write_reg(i.rd, value);
            end
            exp_q.push_back(e);
        end else if (i.opcode == OPC_STORE && i.funct3 inside {3'b000, 3'b001, 3'b010}) begin
            if (bad) begin
                e.fault = 1'b1;
            end else begin
                for (int k = 0; k < n; k++) begin
                    model_mem[byte_index(addr + k)] = sdata[8*k +: 8];
                end
                e.check_rd = 1'b1;           // Stores retire with rd 0
            end
            exp_q.push_back(e);
        end
        // Unsupported encodings retire nothing
    endtask

    // ======================================
    // Stimulus
    // ======================================
    function automatic instruction_t encode_itype(input logic [6:0] opc, input logic [2:0] f3,
                                                  input logic [4:0] rd, input logic [4:0] rs1,
                                                  input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instruction_t encode_stype(input logic [2:0] f3, input logic [4:0] rs2,
                                                  input logic [4:0] rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    task automatic send(input instruction_t i);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = i;
        sent++;
        @(posedge clk);
        while (!instr_ready) begin   // Stalled by hazard or busy bus
            @(posedge clk);
        end
        predict(i);
    endtask

    task automatic addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        send(encode_itype(OPC_OP_IMM, 3'b000, rd, rs1, imm));
    endtask

    task automatic load(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] imm);
        send(encode_itype(OPC_LOAD, f3, rd, rs1, imm));
    endtask

    task automatic store(input logic [2:0] f3, input logic [4:0] rs2, input logic [4:0] rs1,
                         input logic [11:0] imm);
        send(encode_stype(f3, rs2, rs1, imm));
    endtask

    task automatic end_test(input string name, input int first_sent, input int first_errors);
        @(negedge clk);
        instr_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);   // Room for a stray writeback
        $display("Test %s: %0d instructions, %0d errors", name,
                 sent - first_sent, errors - first_errors);
    endtask

    // ======================================
    // Writeback checker and timeout
    // ======================================
    task automatic compare_value(input string name, input word_t got, input word_t want);
        checks++;
        assert (got == want) else begin
            $display("Fail at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, want);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        expect_t e;
        if (arst_n && wb.valid) begin
            assert (exp_q.size() != 0) else begin
                $display("Writeback at %0t with no instruction outstanding", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                compare_value("wb.fault", word_t'(wb.fault), word_t'(e.fault));
                if (e.check_rd) begin
                    compare_value("wb.rd", word_t'(wb.rd), word_t'(e.rd));
                end
                if (e.check_data) begin
                    compare_value("wb.data", wb.data, e.data);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * sent + 100) begin
            $display("Timeout after %0d cycles with %0d instructions sent", cycles, sent);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ======================================
    // Test sequence
    // ======================================
    initial begin
        int first_sent;
        int first_errors;
        int base;
        int addrs [8];
        clk         = 1'b0;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        errors      = 0;
        checks      = 0;
        sent        = 0;
        cycles      = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int k = 0; k < MEM_BYTES; k++) begin
            model_mem[k] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        first_sent   = sent;
        first_errors = errors;
        for (int n = 0; n < 30; n++) begin
            addi(5'(1 + pick(31)), 5'(pick(32)), 12'(pick(4096)));
        end
        end_test("addi_chain", first_sent, first_errors);

        first_sent   = sent;
        first_errors = errors;
        for (int k = 0; k < 8; k++) begin
            addrs[k] = 4 * pick(`LSU_RAM_WORDS);
            store(FUNCT3_LW_SW, 5'(1 + pick(31)), 5'd0, 12'(addrs[k]));
        end
        for (int k = 0; k < 8; k++) begin
            load(FUNCT3_LW_SW, 5'(1 + pick(31)), 5'd0, 12'(addrs[k]));
        end
        end_test("word_store_load", first_sent, first_errors);

        first_sent   = sent;
        first_errors = errors;
        for (int n = 0; n < 6; n++) begin
            base = 4 * pick(`LSU_RAM_WORDS);
            store(FUNCT3_LW_SW, 5'(1 + pick(31)), 5'd0, 12'(base));
            store(FUNCT3_LB_SB, 5'(1 + pick(31)), 5'd0, 12'(base + pick(4)));
            store(FUNCT3_LH_SH, 5'(1 + pick(31)), 5'd0, 12'(base + 2 * pick(2)));
            load(FUNCT3_LW_SW, 5'(1 + pick(31)), 5'd0, 12'(base));
            load(FUNCT3_LB_SB, 5'(1 + pick(31)), 5'd0, 12'(base + pick(4)));
            load(FUNCT3_LBU, 5'(1 + pick(31)), 5'd0, 12'(base + pick(4)));
            load(FUNCT3_LH_SH, 5'(1 + pick(31)), 5'd0, 12'(base + 2 * pick(2)));
            load(FUNCT3_LHU, 5'(1 + pick(31)), 5'd0, 12'(base + 2 * pick(2)));
        end
        end_test("byte_half_lanes", first_sent, first_errors);

        first_sent   = sent;
        first_errors = errors;
        for (int n = 0; n < 4; n++) begin
            base = 4 * pick(250);
            addi(5'd10, 5'd0, 12'(base));
            store(FUNCT3_LW_SW, 5'(1 + pick(31)), 5'd10, 12'd0);
            load(FUNCT3_LW_SW, 5'd11, 5'd10, 12'd0);
            addi(5'd12, 5'd11, 12'(pick(4096)));         // Uses the load result at once
            store(FUNCT3_LW_SW, 5'd12, 5'd10, 12'd4);
            load(FUNCT3_LW_SW, 5'd13, 5'd10, 12'd4);
            addi(5'd14, 5'd13, 12'd0);
            addi(5'd16, 5'd0, 12'(4 * pick(`LSU_RAM_WORDS)));
            store(FUNCT3_LW_SW, 5'd16, 5'd10, 12'd8);
            load(FUNCT3_LW_SW, 5'd15, 5'd10, 12'd8);
            load(FUNCT3_LW_SW, 5'd17, 5'd15, 12'd0);     // Pointer chase
        end
        end_test("dependent_chain", first_sent, first_errors);

        first_sent   = sent;
        first_errors = errors;
        for (int n = 0; n < 4; n++) begin
            base = 4 * pick(`LSU_RAM_WORDS);
            addi(5'd20, 5'd0, 12'(base));
            addi(5'd21, 5'd0, 12'(1 + pick(2047)));      // Nonzero so a stray write shows
            store(FUNCT3_LW_SW, 5'(1 + pick(31)), 5'd20, 12'd0);
            load(FUNCT3_LH_SH, 5'd21, 5'd20, 12'(1 + 2 * pick(2)));
            load(FUNCT3_LW_SW, 5'd21, 5'd20, 12'(1 + pick(3)));
            load(FUNCT3_LHU, 5'd21, 5'd20, 12'(1 + 2 * pick(2)));
            store(FUNCT3_LH_SH, 5'(1 + pick(31)), 5'd20, 12'(1 + 2 * pick(2)));
            store(FUNCT3_LW_SW, 5'(1 + pick(31)), 5'd20, 12'(1 + pick(3)));
            addi(5'd22, 5'd21, 12'd0);                   // x21 must be untouched
            load(FUNCT3_LW_SW, 5'd23, 5'd20, 12'd0);
            send(encode_itype(7'b0110011, 3'b000, 5'd24, 5'd20, 12'd0));  // OP opcode is dropped
            send(encode_itype(OPC_OP_IMM, 3'b010, 5'd24, 5'd20, 12'd1));  // SLTI is dropped
        end
        end_test("misaligned_fault", first_sent, first_errors);

        errors = errors + dut_i.u_mem.u_props.failures;
        $display("Summary: %0d instructions, %0d checks, %0d errors", sent, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+design
design/lsu_pkg.sv
design/register_file.sv
design/lsu_decode_stage.sv
design/load_store_unit.sv
design/lsu_memory_stage.sv
design/data_ram_apb.sv
design/lsu_subsystem_top.sv
testbench/lsu_properties.sv
testbench/lsu_tb.sv
